// ==== frame_pkg.sv ====
// Frame wrapper shared definitions
`default_nettype none

package frame_pkg;

    // Widths with a meaning
    typedef logic [63:0] status_t;
    typedef logic [28:0] ddr_addr_t;
    typedef logic [63:0] ddr_data_t;
    typedef logic [7:0]  ddr_be_t;
    typedef logic [7:0]  burst_cnt_t;
    typedef logic [26:0] dl_addr_t;
    typedef logic [8:0]  coord_t;
    typedef logic [31:0] rgb_t;
    typedef logic [15:0] menumask_t;

    // Loader burst length in 64-bit words
    localparam int BURST_WORDS = 4;

    // Game screen geometry before rotation
    localparam int VIDEO_WIDTH  = 384;
    localparam int VIDEO_HEIGHT = 224;

    // Rotated framebuffer, one 32-bit pixel per column
    localparam logic [31:0] FB_BASE = 32'h2000_0000;
    localparam int FB_STRIDE = VIDEO_HEIGHT * 4;

    // OSD status bit positions
    localparam int ST_NO_ROTATE  = 2;
    localparam int ST_HSIZE_EN   = 19;
    localparam int ST_SHADOW_LSB = 32;
    localparam int ST_SHADOW_2X  = 35;
    localparam int ST_SHADOW_ROT = 36;
    localparam int ST_UART_EN    = 38;
    localparam int ST_FLIP       = 39;

    typedef struct packed {
        logic       rd;
        logic       we;
        ddr_addr_t  addr;
        burst_cnt_t burstcnt;
        ddr_be_t    be;
        ddr_data_t  din;
    } ddr_cmd_t;

    typedef struct packed {
        logic      busy;
        ddr_data_t dout;
        logic      dout_ready;
    } ddr_rsp_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        rgb_t   rgb;
    } pixel_t;

    // Registered settings decoded from the status word
    typedef struct packed {
        logic [2:0] shadowmask;
        logic       shadowmask_2x;
        logic       shadowmask_rot;
        logic       fb_flip;
        logic       rotate_en;
        logic       uart_en;
    } frame_cfg_t;

endpackage

`default_nettype wire

// ==== core_config.sv ====
// OSD status decoder
`timescale 1ns/10ps
`default_nettype none

module core_config (
    input  wire                    clk_sys,
    input  wire                    arst_n,
    input  wire frame_pkg::status_t status,
    input  wire  [6:0]             core_mod,
    input  wire                    direct_video,
    input  wire                    game_tx,
    input  wire  [6:0]             user_in,
    output frame_pkg::frame_cfg_t  cfg,
    output frame_pkg::menumask_t   menumask,
    output logic [6:0]             user_out,
    output logic                   game_rx
);

    import frame_pkg::*;

    logic       rotate_en_d;
    logic       uart_en_d;
    logic [2:0] shadow_d;

    // Vertical game and rotation not turned off in the OSD
    assign rotate_en_d = core_mod[0] & ~status[ST_NO_ROTATE];
    assign uart_en_d   = status[ST_UART_EN];
    assign shadow_d    = status[ST_SHADOW_LSB +: 3];

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            cfg      <= '0;
            menumask <= '0;
            user_out <= 7'h7f;
            game_rx  <= 1'b1;
        end else begin
            cfg.shadowmask     <= shadow_d;
            cfg.shadowmask_2x  <= status[ST_SHADOW_2X];
            cfg.rotate_en      <= rotate_en_d;
            // Mask turns with the screen unless the OSD inverts it
            cfg.shadowmask_rot <= rotate_en_d ^ status[ST_SHADOW_ROT];
            cfg.fb_flip        <= status[ST_FLIP:ST_UART_EN] == 2'd2;
            cfg.uart_en        <= uart_en_d;

            // A set bit hides the menu entry
            menumask <= {
                11'd0,
                1'b1,
                shadow_d == 3'd0,
                ~status[ST_HSIZE_EN],
                ~core_mod[0],
                direct_video
            };

            // UART pins on the user port, idle high otherwise
            user_out <= uart_en_d ? {6'h3f, game_tx} : 7'h7f;
            game_rx  <= uart_en_d ? user_in[1] : 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== ddr_load_reader.sv ====
// Fast ROM loader from DDR
`timescale 1ns/10ps
`default_nettype none

module ddr_load_reader (
    input  wire                       clk_sys,
    input  wire                       arst_n,
    input  wire                       dl_start,
    input  wire frame_pkg::ddr_addr_t dl_base,
    input  wire frame_pkg::dl_addr_t  dl_len,
    output logic                      req,
    input  wire                       ack,
    output frame_pkg::ddr_cmd_t       ddr_cmd,
    input  wire frame_pkg::ddr_rsp_t  ddr_rsp,
    output frame_pkg::dl_addr_t       ioctl_addr,
    output logic [7:0]                ioctl_dout,
    output logic                      ioctl_wr,
    input  wire                       ioctl_wait,
    output logic                      downloading
);

    import frame_pkg::*;

    typedef enum logic [2:0] {IDLE, REQ, READ, RELEASE, DRAIN} state_t;

    state_t     state;
    ddr_addr_t  word_addr;
    dl_addr_t   len_q;
    dl_addr_t   cnt;
    logic [1:0] rcv_cnt;
    logic       rd_q;
    logic       pend;
    ddr_data_t  buf_q [BURST_WORDS];
    ddr_data_t  cur_word;

    assign cur_word = buf_q[cnt[4:3]];

    // Held byte goes out on the first cycle without wait
    assign ioctl_wr = pend & ~ioctl_wait;

    assign ddr_cmd = '{rd: rd_q, we: 1'b0, addr: word_addr,
                       burstcnt: burst_cnt_t'(BURST_WORDS), be: 8'hff, din: 64'd0};

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            state       <= IDLE;
            word_addr   <= '0;
            len_q       <= '0;
            cnt         <= '0;
            rcv_cnt     <= '0;
            rd_q        <= 1'b0;
            pend        <= 1'b0;
            req         <= 1'b0;
            downloading <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (dl_start && dl_len != '0) begin
                        downloading <= 1'b1;
                        word_addr   <= dl_base;
                        len_q       <= dl_len;
                        cnt         <= '0;
                        req         <= 1'b1;
                        state       <= REQ;
                    end
                end
                REQ: begin
                    if (ack) begin
                        rd_q    <= 1'b1;
                        rcv_cnt <= '0;
                        state   <= READ;
                    end
                end
                READ: begin
                    if (rd_q && !ddr_rsp.busy) begin
                        rd_q <= 1'b0;
                    end
                    if (ddr_rsp.dout_ready) begin
                        rcv_cnt <= rcv_cnt + 2'd1;
                        if (rcv_cnt == 2'(BURST_WORDS - 1)) begin
                            req   <= 1'b0;
                            state <= RELEASE;
                        end
                    end
                end
                RELEASE: begin
                    if (!ack) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (pend) begin
                        if (!ioctl_wait) begin
                            pend <= 1'b0;
                            if (cnt == len_q) begin
                                downloading <= 1'b0;
                                state       <= IDLE;
                            end else if (cnt[4:0] == 5'd0) begin
                                // Whole burst consumed, fetch the next one
                                word_addr <= word_addr + ddr_addr_t'(BURST_WORDS);
                                req       <= 1'b1;
                                state     <= REQ;
                            end
                        end
                    end else begin
                        pend <= 1'b1;
                        cnt  <= cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Burst buffer and outgoing byte
    always_ff @(posedge clk_sys) begin
        if (state == READ && ddr_rsp.dout_ready) begin
            buf_q[rcv_cnt] <= ddr_rsp.dout;
        end
        if (state == DRAIN && !pend) begin
            ioctl_addr <= cnt;
            ioctl_dout <= cur_word[{cnt[2:0], 3'b000} +: 8];
        end
    end

endmodule

`default_nettype wire

// ==== fb_rotate_writer.sv ====
// Clockwise rotated framebuffer writer
`timescale 1ns/10ps
`default_nettype none

module fb_rotate_writer (
    input  wire                         clk_sys,
    input  wire                         arst_n,
    input  wire frame_pkg::frame_cfg_t  cfg,
    input  wire                         pix_req,
    input  wire frame_pkg::pixel_t      pix,
    output logic                        pix_ack,
    output logic                        req,
    input  wire                         ack,
    output frame_pkg::ddr_cmd_t         ddr_cmd,
    input  wire frame_pkg::ddr_rsp_t    ddr_rsp
);

    import frame_pkg::*;

    typedef enum logic [1:0] {IDLE, REQ, WRITE, ACK} state_t;

    state_t      state;
    logic        we_q;
    coord_t      col;
    coord_t      row;
    logic [31:0] byte_addr;
    ddr_addr_t   addr_q;
    ddr_be_t     be_q;
    ddr_data_t   din_q;

    // Game line becomes a framebuffer column
    assign col = cfg.fb_flip ? pix.y : coord_t'(VIDEO_HEIGHT - 1) - pix.y;
    assign row = cfg.fb_flip ? coord_t'(VIDEO_WIDTH - 1) - pix.x : pix.x;

    assign byte_addr = FB_BASE + 32'(row) * 32'(FB_STRIDE) + {21'd0, col, 2'b00};

    assign ddr_cmd = '{rd: 1'b0, we: we_q, addr: addr_q,
                       burstcnt: 8'd1, be: be_q, din: din_q};

    // Pixel is stable while pix_req is high
    always_ff @(posedge clk_sys) begin
        if (state == IDLE && pix_req) begin
            addr_q <= byte_addr[31:3];
            be_q   <= byte_addr[2] ? 8'hf0 : 8'h0f;
            din_q  <= {pix.rgb, pix.rgb};
        end
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            we_q    <= 1'b0;
            req     <= 1'b0;
            pix_ack <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (pix_req) begin
                        if (!cfg.rotate_en) begin
                            // Nothing to store, just complete the handshake
                            pix_ack <= 1'b1;
                            state   <= ACK;
                        end else if (!ack) begin
                            req   <= 1'b1;
                            state <= REQ;
                        end
                    end
                end
                REQ: begin
                    if (ack) begin
                        we_q  <= 1'b1;
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    if (!ddr_rsp.busy) begin
                        we_q    <= 1'b0;
                        req     <= 1'b0;
                        pix_ack <= 1'b1;
                        state   <= ACK;
                    end
                end
                ACK: begin
                    if (!pix_req) begin
                        pix_ack <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== ddr_arbiter.sv ====
// DDR port arbiter for loader and rotator
`timescale 1ns/10ps
`default_nettype none

module ddr_arbiter (
    input  wire                       clk_sys,
    input  wire                       arst_n,
    input  wire                       ld_req,
    output logic                      ld_ack,
    input  wire frame_pkg::ddr_cmd_t  ld_cmd,
    output frame_pkg::ddr_rsp_t       ld_rsp,
    input  wire                       rot_req,
    output logic                      rot_ack,
    input  wire frame_pkg::ddr_cmd_t  rot_cmd,
    output frame_pkg::ddr_rsp_t       rot_rsp,
    output frame_pkg::ddr_cmd_t       ddr_cmd,
    input  wire frame_pkg::ddr_rsp_t  ddr_rsp
);

    import frame_pkg::*;

    typedef enum logic [1:0] {NONE, LOAD, ROT} owner_t;

    owner_t owner;

    // Losing client sees a busy port with no read data
    function automatic ddr_rsp_t route(input logic own, input ddr_rsp_t rsp);
        ddr_rsp_t r;
        r.busy       = own ? rsp.busy : 1'b1;
        r.dout       = rsp.dout;
        r.dout_ready = own & rsp.dout_ready;
        return r;
    endfunction

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            owner <= NONE;
        end else begin
            case (owner)
                NONE: begin
                    // Loader first when both wait
                    if (ld_req) begin
                        owner <= LOAD;
                    end else if (rot_req) begin
                        owner <= ROT;
                    end
                end
                LOAD:    if (!ld_req) owner <= NONE;
                ROT:     if (!rot_req) owner <= NONE;
                default: owner <= NONE;
            endcase
        end
    end

    assign ld_ack  = owner == LOAD;
    assign rot_ack = owner == ROT;

    assign ld_rsp  = route(ld_ack, ddr_rsp);
    assign rot_rsp = route(rot_ack, ddr_rsp);

    always_comb begin
        ddr_cmd = '0;
        case (owner)
            LOAD:    ddr_cmd = ld_cmd;
            ROT:     ddr_cmd = rot_cmd;
            default: ddr_cmd = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== mister_frame_top.sv ====
// Frame wrapper DDR sharing top level
`timescale 1ns/10ps
`default_nettype none

module mister_frame_top (
    input  wire                         clk_sys,
    input  wire                         arst_n,
    // OSD and user port
    input  wire frame_pkg::status_t     status,
    input  wire  [6:0]                  core_mod,
    input  wire                         direct_video,
    input  wire                         game_tx,
    input  wire  [6:0]                  user_in,
    output frame_pkg::frame_cfg_t       cfg,
    output frame_pkg::menumask_t        menumask,
    output logic [6:0]                  user_out,
    output logic                        game_rx,
    // Fast load
    input  wire                         dl_start,
    input  wire frame_pkg::ddr_addr_t   dl_base,
    input  wire frame_pkg::dl_addr_t    dl_len,
    output frame_pkg::dl_addr_t         ioctl_addr,
    output logic [7:0]                  ioctl_dout,
    output logic                        ioctl_wr,
    input  wire                         ioctl_wait,
    output logic                        downloading,
    // Game pixels
    input  wire                         pix_req,
    input  wire frame_pkg::pixel_t      pix,
    output logic                        pix_ack,
    // DDR port
    output frame_pkg::ddr_cmd_t         ddr_cmd,
    input  wire frame_pkg::ddr_rsp_t    ddr_rsp
);

    import frame_pkg::*;

    logic     ld_req;
    logic     ld_ack;
    ddr_cmd_t ld_cmd;
    ddr_rsp_t ld_rsp;
    logic     rot_req;
    logic     rot_ack;
    ddr_cmd_t rot_cmd;
    ddr_rsp_t rot_rsp;

    core_config u_config (
        .clk_sys      (clk_sys),
        .arst_n       (arst_n),
        .status       (status),
        .core_mod     (core_mod),
        .direct_video (direct_video),
        .game_tx      (game_tx),
        .user_in      (user_in),
        .cfg          (cfg),
        .menumask     (menumask),
        .user_out     (user_out),
        .game_rx      (game_rx)
    );

    ddr_load_reader u_loader (
        .clk_sys     (clk_sys),
        .arst_n      (arst_n),
        .dl_start    (dl_start),
        .dl_base     (dl_base),
        .dl_len      (dl_len),
        .req         (ld_req),
        .ack         (ld_ack),
        .ddr_cmd     (ld_cmd),
        .ddr_rsp     (ld_rsp),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .ioctl_wait  (ioctl_wait),
        .downloading (downloading)
    );

    fb_rotate_writer u_rotate (
        .clk_sys (clk_sys),
        .arst_n  (arst_n),
        .cfg     (cfg),
        .pix_req (pix_req),
        .pix     (pix),
        .pix_ack (pix_ack),
        .req     (rot_req),
        .ack     (rot_ack),
        .ddr_cmd (rot_cmd),
        .ddr_rsp (rot_rsp)
    );

    ddr_arbiter u_arbiter (
        .clk_sys (clk_sys),
        .arst_n  (arst_n),
        .ld_req  (ld_req),
        .ld_ack  (ld_ack),
        .ld_cmd  (ld_cmd),
        .ld_rsp  (ld_rsp),
        .rot_req (rot_req),
        .rot_ack (rot_ack),
        .rot_cmd (rot_cmd),
        .rot_rsp (rot_rsp),
        .ddr_cmd (ddr_cmd),
        .ddr_rsp (ddr_rsp)
    );

endmodule

`default_nettype wire

// ==== tb_mister_frame_top.sv ====
// Frame wrapper testbench
`timescale 1ns/10ps
`default_nettype none

module tb_mister_frame_top;

    import frame_pkg::*;

    localparam int NUM_ROWS = 14;
    localparam logic [1:0] K_CFG    = 2'd0;
    localparam logic [1:0] K_LOAD   = 2'd1;
    localparam logic [1:0] K_PIX    = 2'd2;
    localparam logic [1:0] K_SHARED = 2'd3;

    typedef struct packed {
        logic [1:0] kind;
        status_t    status;
        logic [6:0] core_mod;
        logic       dv;
        ddr_addr_t  base;
        dl_addr_t   len;
        logic [7:0] npix;
        coord_t     x0;
        coord_t     y0;
    } test_row_t;

    logic       clk_sys;
    logic       arst_n;
    status_t    status;
    logic [6:0] core_mod;
    logic       direct_video;
    logic       game_tx;
    logic [6:0] user_in;
    frame_cfg_t cfg;
    menumask_t  menumask;
    logic [6:0] user_out;
    logic       game_rx;
    logic       dl_start;
    ddr_addr_t  dl_base;
    dl_addr_t   dl_len;
    dl_addr_t   ioctl_addr;
    logic [7:0] ioctl_dout;
    logic       ioctl_wr;
    logic       ioctl_wait;
    logic       downloading;
    logic       pix_req;
    pixel_t     pix;
    logic       pix_ack;
    ddr_cmd_t   ddr_cmd;
    ddr_rsp_t   ddr_rsp;

    test_row_t   rows [NUM_ROWS];
    logic        table_ready = 1'b0;
    logic [31:0] rng = 32'h95813e8d;
    int          err_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          strobe_cnt = 0;
    ddr_addr_t   cur_base = '0;
    int          cur_len = 0;
    ddr_data_t   rd_words [$];
    ddr_addr_t   wr_addr [$];
    ddr_be_t     wr_be [$];
    ddr_data_t   wr_din [$];
    ddr_addr_t   exp_addr [$];
    ddr_be_t     exp_be [$];
    ddr_data_t   exp_din [$];

    mister_frame_top UUT (.*);

    always #50 clk_sys = ~clk_sys;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Memory contents, every address bit matters
    function automatic ddr_data_t word_hash(input ddr_addr_t a);
        ddr_data_t h;
        h = {35'd0, a} * 64'h9e37_79b9_7f4a_7c15;
        return h ^ {a, a, a[5:0]};
    endfunction

    function automatic test_row_t make_row(input logic [1:0] kind, input status_t st,
                                           input logic [6:0] cm, input logic dv,
                                           input ddr_addr_t base, input dl_addr_t len,
                                           input logic [7:0] npix, input coord_t x0,
                                           input coord_t y0);
        test_row_t r;
        r.kind     = kind;
        r.status   = st;
        r.core_mod = cm;
        r.dv       = dv;
        r.base     = base;
        r.len      = len;
        r.npix     = npix;
        r.x0       = x0;
        r.y0       = y0;
        return r;
    endfunction

    function automatic string kind_name(input logic [1:0] kind);
        case (kind)
            K_CFG:   return "config decode";
            K_LOAD:  return "fast load";
            K_PIX:   return "rotated write";
            default: return "shared port";
        endcase
    endfunction

    // Pixels walk across the screen from the start point
    function automatic pixel_t pixel_at(input test_row_t r, input int i);
        pixel_t    p;
        ddr_data_t h;
        p.x   = coord_t'((int'(r.x0) + i * 37) % VIDEO_WIDTH);
        p.y   = coord_t'((int'(r.y0) + i * 53) % VIDEO_HEIGHT);
        h     = word_hash({11'd0, p.x, p.y});
        p.rgb = {8'h00, h[23:0]};
        return p;
    endfunction

    task automatic log_error(input string msg);
        $display("%s", msg);
        err_cnt++;
    endtask

    task automatic fill_table();
        rows[0]  = make_row(K_CFG, '0, 7'h00, 1'b0, '0, '0, 8'd0, 9'd0, 9'd0);
        rows[1]  = make_row(K_CFG, 64'h0000_005d_0008_0000, 7'h01, 1'b1, '0, '0, 8'd0, 9'd0, 9'd0);
        rows[2]  = make_row(K_CFG, 64'h0000_0082_0000_0004, 7'h41, 1'b0, '0, '0, 8'd0, 9'd0, 9'd0);
        rows[3]  = make_row(K_CFG, 64'h0000_00c0_0000_0000, 7'h00, 1'b1, '0, '0, 8'd0, 9'd0, 9'd0);
        rows[4]  = make_row(K_LOAD, '0, 7'h00, 1'b0, 29'h0000_1000, 27'd64, 8'd0, 9'd0, 9'd0);
        rows[5]  = make_row(K_LOAD, '0, 7'h00, 1'b0, 29'h0123_4567, 27'd77, 8'd0, 9'd0, 9'd0);
        rows[6]  = make_row(K_PIX, '0, 7'h01, 1'b0, '0, '0, 8'd1, 9'd0, 9'd0);
        rows[7]  = make_row(K_PIX, '0, 7'h01, 1'b0, '0, '0, 8'd1, 9'd383, 9'd223);
        rows[8]  = make_row(K_PIX, '0, 7'h01, 1'b0, '0, '0, 8'd6, 9'd5, 9'd17);
        // Flip set, UART clear
        rows[9]  = make_row(K_PIX, 64'h0000_0080_0000_0000, 7'h01, 1'b0, '0, '0, 8'd1, 9'd0, 9'd223);
        rows[10] = make_row(K_PIX, 64'h0000_0080_0000_0000, 7'h01, 1'b0, '0, '0, 8'd1, 9'd383, 9'd0);
        rows[11] = make_row(K_PIX, 64'h0000_0080_0000_0000, 7'h01, 1'b0, '0, '0, 8'd6, 9'd100, 9'd50);
        rows[12] = make_row(K_PIX, 64'h4, 7'h01, 1'b0, '0, '0, 8'd4, 9'd10, 9'd10);
        rows[13] = make_row(K_SHARED, '0, 7'h01, 1'b0, 29'h0abc_d000, 27'd45, 8'd8, 9'd200, 9'd100);
    endtask

    task automatic check_config(input test_row_t r);
        frame_cfg_t exp_cfg;
        menumask_t  exp_mask;
        logic [6:0] exp_uo;
        logic       exp_rx;
        exp_cfg.shadowmask     = r.status[ST_SHADOW_LSB +: 3];
        exp_cfg.shadowmask_2x  = r.status[ST_SHADOW_2X];
        exp_cfg.rotate_en      = r.core_mod[0] & ~r.status[ST_NO_ROTATE];
        exp_cfg.shadowmask_rot = exp_cfg.rotate_en ^ r.status[ST_SHADOW_ROT];
        exp_cfg.fb_flip        = {r.status[ST_FLIP], r.status[ST_UART_EN]} == 2'b10;
        exp_cfg.uart_en        = r.status[ST_UART_EN];
        exp_mask = {11'd0, 1'b1, r.status[ST_SHADOW_LSB +: 3] == 3'd0,
                    ~r.status[ST_HSIZE_EN], ~r.core_mod[0], r.dv};
        exp_uo = exp_cfg.uart_en ? {6'h3f, game_tx} : 7'h7f;
        exp_rx = exp_cfg.uart_en ? user_in[1] : 1'b1;
        assert (cfg == exp_cfg)
            else log_error($sformatf("ERROR cfg: got %h expected %h", cfg, exp_cfg));
        assert (menumask == exp_mask)
            else log_error($sformatf("ERROR menumask: got %h expected %h", menumask, exp_mask));
        assert (user_out == exp_uo)
            else log_error($sformatf("ERROR user_out: got %h expected %h", user_out, exp_uo));
        assert (game_rx == exp_rx)
            else log_error($sformatf("ERROR game_rx: got %h expected %h", game_rx, exp_rx));
    endtask

    // Framebuffer turned clockwise, flip mirrors both axes
    task automatic expect_write(input pixel_t p, input logic flip);
        int          col;
        int          row;
        logic [31:0] ba;
        col = flip ? int'(p.y) : VIDEO_HEIGHT - 1 - int'(p.y);
        row = flip ? VIDEO_WIDTH - 1 - int'(p.x) : int'(p.x);
        ba  = FB_BASE + row * FB_STRIDE + col * 4;
        exp_addr.push_back(ba[31:3]);
        exp_be.push_back(ba[2] ? 8'hf0 : 8'h0f);
        exp_din.push_back({p.rgb, p.rgb});
    endtask

    task automatic send_pixels(input test_row_t r, input logic rot, input logic flip);
        pixel_t p;
        for (int i = 0; i < r.npix; i++) begin
            p = pixel_at(r, i);
            if (rot) begin
                expect_write(p, flip);
            end
            @(posedge clk_sys);
            #10;
            pix     = p;
            pix_req = 1'b1;
            while (!pix_ack) @(negedge clk_sys);
            @(posedge clk_sys);
            #10;
            pix_req = 1'b0;
            while (pix_ack) @(negedge clk_sys);
        end
    endtask

    task automatic run_load(input test_row_t r);
        @(posedge clk_sys);
        #10;
        dl_base  = r.base;
        dl_len   = r.len;
        dl_start = 1'b1;
        @(posedge clk_sys);
        #10;
        dl_start = 1'b0;
        assert (downloading) else log_error("downloading did not rise after dl_start");
        while (downloading) @(negedge clk_sys);
        assert (strobe_cnt == r.len)
            else log_error($sformatf("Download ended after %0d bytes, %0d expected",
                                     strobe_cnt, r.len));
    endtask

    task automatic run_test(input int idx);
        test_row_t r;
        int        err0;
        logic      rot;
        logic      flip;
        r    = rows[idx];
        err0 = err_cnt;
        rot  = r.core_mod[0] & ~r.status[ST_NO_ROTATE];
        flip = {r.status[ST_FLIP], r.status[ST_UART_EN]} == 2'b10;
        wr_addr.delete();
        wr_be.delete();
        wr_din.delete();
        exp_addr.delete();
        exp_be.delete();
        exp_din.delete();
        @(posedge clk_sys);
        #10;
        status       = r.status;
        core_mod     = r.core_mod;
        direct_video = r.dv;
        game_tx      = ~idx[0];
        user_in      = 7'(idx * 19);
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_config(r);
        cur_base   = r.base;
        cur_len    = (r.kind == K_LOAD || r.kind == K_SHARED) ? int'(r.len) : 0;
        strobe_cnt = 0;
        fork
            if (cur_len != 0) run_load(r);
            if (r.kind == K_PIX || r.kind == K_SHARED) send_pixels(r, rot, flip);
        join
        assert (wr_addr.size() == exp_addr.size())
            else log_error($sformatf("Saw %0d DDR writes where %0d were expected",
                                     wr_addr.size(), exp_addr.size()));
        for (int k = 0; k < wr_addr.size() && k < exp_addr.size(); k++) begin
            assert (wr_addr[k] == exp_addr[k]) else log_error($sformatf(
                "ERROR ddr_cmd.addr: got %h expected %h", wr_addr[k], exp_addr[k]));
            assert (wr_be[k] == exp_be[k]) else log_error($sformatf(
                "ERROR ddr_cmd.be: got %h expected %h", wr_be[k], exp_be[k]));
            assert (wr_din[k] == exp_din[k]) else log_error($sformatf(
                "ERROR ddr_cmd.din: got %h expected %h", wr_din[k], exp_din[k]));
        end
        if (err_cnt == err0) pass_cnt++;
        else fail_cnt++;
        $display("test %0d %s: %s", idx, kind_name(r.kind), err_cnt == err0 ? "pass" : "FAIL");
    endtask

    // DDR model, busy and ioctl_wait from the LCG
    always @(posedge clk_sys) begin
        #10;
        rng = lcg_next(rng);
        ddr_rsp.busy = rng[31:30] == 2'b00;
        ioctl_wait   = rng[29:28] == 2'b00;
        if (rd_words.size() > 0 && rng[27:26] != 2'b00) begin
            ddr_rsp.dout       = rd_words.pop_front();
            ddr_rsp.dout_ready = 1'b1;
        end else begin
            ddr_rsp.dout_ready = 1'b0;
        end
    end

    // Values here hold until the next rising edge
    always @(negedge clk_sys) begin : monitor
        ddr_data_t exp_word;
        logic [7:0] exp_byte;
        if (arst_n) begin
            if (ddr_cmd.rd && !ddr_rsp.busy) begin
                assert (ddr_cmd.burstcnt == BURST_WORDS) else log_error($sformatf(
                    "ERROR ddr_cmd.burstcnt: got %h expected %h", ddr_cmd.burstcnt, 8'd4));
                for (int k = 0; k < BURST_WORDS; k++) begin
                    rd_words.push_back(word_hash(ddr_cmd.addr + ddr_addr_t'(k)));
                end
            end
            if (ddr_cmd.we && !ddr_rsp.busy) begin
                assert (ddr_cmd.burstcnt == 8'd1) else log_error($sformatf(
                    "ERROR ddr_cmd.burstcnt: got %h expected %h", ddr_cmd.burstcnt, 8'd1));
                wr_addr.push_back(ddr_cmd.addr);
                wr_be.push_back(ddr_cmd.be);
                wr_din.push_back(ddr_cmd.din);
            end
            if (ddr_rsp.dout_ready) begin
                assert (UUT.ld_ack) else log_error("Read data arrived outside a loader burst");
            end
            if (ioctl_wr) begin
                assert (!ioctl_wait) else log_error("Byte strobe issued while ioctl_wait high");
                assert (strobe_cnt < cur_len) else log_error("Byte strobe beyond download length");
                exp_word = word_hash(cur_base + ddr_addr_t'(strobe_cnt / 8));
                exp_byte = exp_word[(strobe_cnt % 8) * 8 +: 8];
                assert (ioctl_addr == dl_addr_t'(strobe_cnt)) else log_error($sformatf(
                    "ERROR ioctl_addr: got %h expected %h", ioctl_addr, dl_addr_t'(strobe_cnt)));
                assert (ioctl_dout == exp_byte) else log_error($sformatf(
                    "ERROR ioctl_dout: got %h expected %h", ioctl_dout, exp_byte));
                strobe_cnt++;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = 100;
        for (int i = 0; i < NUM_ROWS; i++) begin
            limit += 200 * int'(rows[i].len) + 100 * int'(rows[i].npix) + 50;
        end
        repeat (limit) @(posedge clk_sys);
        $display("Timeout: tests still running after %0d clock cycles", limit);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        clk_sys      = 1'b0;
        arst_n       = 1'b0;
        status       = '0;
        core_mod     = '0;
        direct_video = 1'b0;
        game_tx      = 1'b0;
        user_in      = '0;
        dl_start     = 1'b0;
        dl_base      = '0;
        dl_len       = '0;
        ioctl_wait   = 1'b0;
        pix_req      = 1'b0;
        pix          = '0;
        ddr_rsp      = '0;
        fill_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk_sys);
        #10;
        arst_n = 1'b1;
        @(negedge clk_sys);
        assert (!ddr_cmd.rd && !ddr_cmd.we && !pix_ack && !ioctl_wr && !downloading)
            else log_error("Control outputs not low after reset");
        assert (user_out == 7'h7f)
            else log_error($sformatf("ERROR user_out: got %h expected %h", user_out, 7'h7f));
        assert (cfg == '0)
            else log_error($sformatf("ERROR cfg: got %h expected %h", cfg, 8'h00));
        assert (menumask == '0)
            else log_error($sformatf("ERROR menumask: got %h expected %h", menumask, 16'h0000));
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_test(i);
        end
        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 NUM_ROWS, pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mister_frame_top.f ====
frame_pkg.sv
core_config.sv
ddr_load_reader.sv
fb_rotate_writer.sv
ddr_arbiter.sv
mister_frame_top.sv
tb_mister_frame_top.sv

// ==== Bender.yml ====
package:
  name: mister_frame_top

sources:
  - frame_pkg.sv
  - core_config.sv
  - ddr_load_reader.sv
  - fb_rotate_writer.sv
  - ddr_arbiter.sv
  - mister_frame_top.sv
  - target: simulation
    files:
      - tb_mister_frame_top.sv
